// File: source/pps_sync_defs.svh
// PPS sync constants
// Generator periods, delay-line depth and register map addresses shared by
// the register block and the PPS data path

`ifndef PPS_SYNC_DEFS_SVH
`define PPS_SYNC_DEFS_SVH

// Internal PPS periods in base reference clock cycles, scaled down for
// simulation. The 10M value stands for a 10 MHz reference
`define PPS_PERIOD_10M 400
`define PPS_PERIOD_25M 1000

// Number of stages in the PPS delay line, output register included
`define PPS_DELAY_DEPTH 64

// Register addresses on the configuration bus
`define REG_ADDR_CTRL     2'd0
`define REG_ADDR_SYNC_DLY 2'd1
`define REG_ADDR_PPS_DLY  2'd2
`define REG_ADDR_STATUS   2'd3

`endif

// File: source/pps_sync_pkg.sv
// PPS sync types
// Width typedefs, configuration and bus structs, and the LMK sync FSM states

`default_nettype none

package pps_sync_pkg;

  // Source select: 0 internal 10M, 1 internal 25M, anything else external
  typedef logic [1:0]  pps_sel_t;
  typedef logic [7:0]  sync_delay_t;
  typedef logic [5:0]  pps_delay_t;
  typedef logic [1:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Configuration fields as held by the register block
  typedef struct packed {
    pps_sel_t    pps_sel;
    logic        sync_trigger;
    sync_delay_t sync_delay;
    pps_delay_t  pps_delay;
  } pps_cfg_t;

  // Bus command, valid while req is high
  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef enum logic [1:0] {IDLE, ARMED, COUNT, DONE} sync_state_t;

endpackage

`default_nettype wire

// File: source/pps_pulse_gen.sv
// Internal PPS generator
// Free-running modulo-PERIOD counter with a registered compare that gives a
// pulse train high for the first quarter of each period

`timescale 1ns/1ps
`default_nettype none

`include "pps_sync_defs.svh"

module pps_pulse_gen #(
  parameter int PERIOD = `PPS_PERIOD_10M
) (
  input  wire  base_ref_clk,
  input  wire  brc_rst,
  output logic pps_o
);

  localparam int CNT_W       = $clog2(PERIOD);
  localparam int HIGH_CYCLES = PERIOD / 4;

  logic [CNT_W-1:0] cnt;

  // Counter wraps after PERIOD cycles and restarts from zero on reset
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      cnt <= '0;
    end else if (cnt == CNT_W'(PERIOD - 1)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // 25% duty cycle, one cycle behind the counter
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      pps_o <= 1'b0;
    end else begin
      pps_o <= (cnt < CNT_W'(HIGH_CYCLES));
    end
  end

endmodule

`default_nettype wire

// File: source/pps_source_select.sv
// PPS source select
// Generates the two internal PPS trains, double-registers the external PPS
// and registers the selected source onto the common PPS line

`timescale 1ns/1ps
`default_nettype none

`include "pps_sync_defs.svh"

module pps_source_select
  import pps_sync_pkg::*;
(
  input  wire      base_ref_clk,
  input  wire      brc_rst,
  input  wire      pps_ext_i,
  input  pps_sel_t pps_sel_i,
  output logic     pps_o
);

  localparam pps_sel_t SEL_INT_10M = 2'd0;
  localparam pps_sel_t SEL_INT_25M = 2'd1;

  logic pps_int_10m;
  logic pps_int_25m;
  logic pps_ext_meta;
  logic pps_ext_sync;

  // ------------------------------------------------------------
  // Internal generators, one per reference rate
  // ------------------------------------------------------------
  pps_pulse_gen #(
    .PERIOD (`PPS_PERIOD_10M)
  ) u_gen_10m (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_o        (pps_int_10m)
  );

  pps_pulse_gen #(
    .PERIOD (`PPS_PERIOD_25M)
  ) u_gen_25m (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_o        (pps_int_25m)
  );

  // External PPS is asynchronous to the board clock, so two flops guard
  // the mux against metastability
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      pps_ext_meta <= 1'b0;
      pps_ext_sync <= 1'b0;
    end else begin
      pps_ext_meta <= pps_ext_i;
      pps_ext_sync <= pps_ext_meta;
    end
  end

  // Switching source is not aligned to any PPS edge and may glitch once
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      pps_o <= 1'b0;
    end else begin
      case (pps_sel_i)
        SEL_INT_10M: pps_o <= pps_int_10m;
        SEL_INT_25M: pps_o <= pps_int_25m;
        default:     pps_o <= pps_ext_sync;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/pps_sync_regs.sv
// PPS sync configuration registers
// Serves the four-phase req/ack bus, holds CTRL, SYNC_DLY and PPS_DLY and
// reports the LMK sync done flag through STATUS

`timescale 1ns/1ps
`default_nettype none

`include "pps_sync_defs.svh"

module pps_sync_regs
  import pps_sync_pkg::*;
(
  input  wire        base_ref_clk,
  input  wire        brc_rst,
  input  wire        bus_req_i,
  input  reg_req_t   bus_cmd_i,
  output logic       bus_ack_o,
  output reg_data_t  bus_rdata_o,
  input  wire        sync_done_i,
  output pps_cfg_t   cfg_o
);

  pps_cfg_t  cfg_q;
  reg_data_t rd_value;

  // Read mux, fields placed at their register bit positions
  always_comb begin
    case (bus_cmd_i.addr)
      `REG_ADDR_CTRL:     rd_value = {11'd0, cfg_q.sync_trigger, 2'd0, cfg_q.pps_sel};
      `REG_ADDR_SYNC_DLY: rd_value = {8'd0, cfg_q.sync_delay};
      `REG_ADDR_PPS_DLY:  rd_value = {10'd0, cfg_q.pps_delay};
      default:            rd_value = {15'd0, sync_done_i};
    endcase
  end

  // ------------------------------------------------------------
  // Four-phase handshake
  // ------------------------------------------------------------
  // The access happens once, on the first cycle with req high and ack low.
  // Ack then stays up until req is seen low again
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      bus_ack_o <= 1'b0;
      cfg_q     <= '0;
    end else if (bus_req_i && !bus_ack_o) begin
      bus_ack_o <= 1'b1;
      if (bus_cmd_i.write) begin
        case (bus_cmd_i.addr)
          `REG_ADDR_CTRL: begin
            cfg_q.pps_sel      <= bus_cmd_i.wdata[1:0];
            cfg_q.sync_trigger <= bus_cmd_i.wdata[4];
          end
          `REG_ADDR_SYNC_DLY: cfg_q.sync_delay <= bus_cmd_i.wdata[7:0];
          `REG_ADDR_PPS_DLY:  cfg_q.pps_delay  <= bus_cmd_i.wdata[5:0];
          // STATUS is read-only
          default: ;
        endcase
      end
    end else if (!bus_req_i && bus_ack_o) begin
      bus_ack_o <= 1'b0;
    end
  end

  // Read data is captured with the access and stays valid during ack
  always_ff @(posedge base_ref_clk) begin
    if (bus_req_i && !bus_ack_o) begin
      bus_rdata_o <= rd_value;
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: source/lmk_sync_ctrl.sv
// LMK SYNC control
// Waits for a trigger, then issues a one-cycle SYNC a programmable number of
// cycles after the next PPS rising edge and flags completion until released

`timescale 1ns/1ps
`default_nettype none

module lmk_sync_ctrl
  import pps_sync_pkg::*;
(
  input  wire         base_ref_clk,
  input  wire         brc_rst,
  input  wire         pps_i,
  input  wire         sync_trigger_i,
  input  sync_delay_t sync_delay_i,
  output logic        lmk_sync_o,
  output logic        sync_done_o
);

  sync_state_t state;
  sync_delay_t delay_cnt;
  logic        pps_d;
  logic        pps_rise;
  logic        sync_int;

  // ------------------------------------------------------------
  // PPS edge detect
  // ------------------------------------------------------------
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      pps_d <= 1'b0;
    end else begin
      pps_d <= pps_i;
    end
  end

  assign pps_rise = pps_i & ~pps_d;

  // ------------------------------------------------------------
  // Sync FSM
  // ------------------------------------------------------------
  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      state       <= IDLE;
      sync_int    <= 1'b0;
      sync_done_o <= 1'b0;
    end else begin
      case (state)
        // Nothing happens until software sets the trigger
        IDLE: begin
          if (sync_trigger_i) begin
            state <= ARMED;
          end
        end
        // Delay is reloaded every cycle so the latest setting is used
        ARMED: begin
          delay_cnt <= sync_delay_i;
          if (pps_rise) begin
            state <= COUNT;
          end
        end
        COUNT: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) begin
            sync_int <= 1'b1;
            state    <= DONE;
          end
        end
        // Done is held until the trigger goes away, which rearms nothing
        DONE: begin
          sync_int    <= 1'b0;
          sync_done_o <= 1'b1;
          if (!sync_trigger_i) begin
            sync_done_o <= 1'b0;
            state       <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Falling edge capture gives the LMK half a cycle of hold margin
  always_ff @(negedge base_ref_clk) begin
    if (brc_rst) begin
      lmk_sync_o <= 1'b0;
    end else begin
      lmk_sync_o <= sync_int;
    end
  end

endmodule

`default_nettype wire

// File: source/pps_delay_line.sv
// PPS delay line
// Shift register with a programmable registered tap, delaying the PPS by
// the tap value plus one cycle

`timescale 1ns/1ps
`default_nettype none

`include "pps_sync_defs.svh"

module pps_delay_line
  import pps_sync_pkg::*;
(
  input  wire        base_ref_clk,
  input  wire        brc_rst,
  input  wire        pps_i,
  input  pps_delay_t pps_delay_i,
  output logic       pps_dly_o
);

  localparam int DEPTH = `PPS_DELAY_DEPTH;

  // The output register is the last stage, so the chain holds one less
  logic [DEPTH-2:0] shreg;
  logic [DEPTH-1:0] taps;

  // Tap 0 is the live input, which makes the minimum delay one cycle
  assign taps = {shreg, pps_i};

  always_ff @(posedge base_ref_clk) begin
    if (brc_rst) begin
      shreg     <= '0;
      pps_dly_o <= 1'b0;
    end else begin
      shreg     <= {shreg[DEPTH-3:0], pps_i};
      pps_dly_o <= taps[pps_delay_i];
    end
  end

endmodule

`default_nettype wire

// File: source/pps_sync_top.sv
// PPS conditioning top level
// Register block, source select, LMK sync control and delay line, all on
// the base reference clock

`timescale 1ns/1ps
`default_nettype none

module pps_sync_top
  import pps_sync_pkg::*;
(
  input  wire       base_ref_clk,
  input  wire       brc_rst,
  input  wire       pps_ext_i,
  input  wire       bus_req_i,
  input  reg_req_t  bus_cmd_i,
  output logic      bus_ack_o,
  output reg_data_t bus_rdata_o,
  output logic      pps_o,
  output logic      pps_dly_o,
  output logic      lmk_sync_o
);

  pps_cfg_t cfg;
  logic     sync_done;

  pps_sync_regs u_regs (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .bus_req_i    (bus_req_i),
    .bus_cmd_i    (bus_cmd_i),
    .bus_ack_o    (bus_ack_o),
    .bus_rdata_o  (bus_rdata_o),
    .sync_done_i  (sync_done),
    .cfg_o        (cfg)
  );

  // Selected PPS feeds the output, the sync FSM and the delay line
  pps_source_select u_source_select (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_ext_i    (pps_ext_i),
    .pps_sel_i    (cfg.pps_sel),
    .pps_o        (pps_o)
  );

  lmk_sync_ctrl u_sync_ctrl (
    .base_ref_clk   (base_ref_clk),
    .brc_rst        (brc_rst),
    .pps_i          (pps_o),
    .sync_trigger_i (cfg.sync_trigger),
    .sync_delay_i   (cfg.sync_delay),
    .lmk_sync_o     (lmk_sync_o),
    .sync_done_o    (sync_done)
  );

  pps_delay_line u_delay_line (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_i        (pps_o),
    .pps_delay_i  (cfg.pps_delay),
    .pps_dly_o    (pps_dly_o)
  );

endmodule

`default_nettype wire

// File: bench/pps_sync_checker.sv
// PPS sync protocol checker
// Concurrent assertions on the register bus handshake, the SYNC pulse width
// and the done flag release

`timescale 1ns/1ps
`default_nettype none

module pps_sync_checker (
  input wire base_ref_clk,
  input wire brc_rst,
  input wire bus_req_i,
  input wire bus_ack_i,
  input wire lmk_sync_i,
  input wire sync_done_i,
  input wire sync_trigger_i
);

  // Ack only answers a request that was already on the bus
  ack_needs_req: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    $rose(bus_ack_i) |-> $past(bus_req_i))
    else $error("ack rose without a pending req");

  // Ack is held for as long as the master keeps req up
  ack_held: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    (bus_ack_i && bus_req_i) |=> bus_ack_i)
    else $error("ack dropped while req was still high");

  // SYNC is a single cycle wide
  sync_one_cycle: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    $rose(lmk_sync_i) |=> !lmk_sync_i)
    else $error("lmk_sync lasted more than one cycle");

  // Done may outlive the trigger by one cycle only
  done_needs_trigger: assert property (@(posedge base_ref_clk) disable iff (brc_rst)
    (sync_done_i && !sync_trigger_i) |=> !sync_done_i)
    else $error("sync_done stayed high without trigger");

endmodule

bind pps_sync_top pps_sync_checker u_checker (
  .base_ref_clk   (base_ref_clk),
  .brc_rst        (brc_rst),
  .bus_req_i      (bus_req_i),
  .bus_ack_i      (bus_ack_o),
  .lmk_sync_i     (lmk_sync_o),
  .sync_done_i    (sync_done),
  .sync_trigger_i (cfg.sync_trigger)
);

`default_nettype wire

// File: bench/pps_sync_tb.sv
// PPS sync testbench
// Drives the register bus and external PPS from an LFSR and compares the
// PPS, delayed PPS and LMK SYNC outputs against a cycle model

`timescale 1ns/1ps
`default_nettype none

`include "pps_sync_defs.svh"

module pps_sync_tb
  import pps_sync_pkg::*;
;

  localparam int P10 = `PPS_PERIOD_10M;
  localparam int P25 = `PPS_PERIOD_25M;
  localparam int EXT_ROUNDS = 12;
  localparam int RUN_CYCLES = 8 * P10 + 4 * P25 + 2 * EXT_ROUNDS * 100 + 2000;

  logic        base_ref_clk;
  logic        brc_rst;
  logic        pps_ext_i;
  logic        bus_req;
  reg_req_t    bus_cmd;
  logic        bus_ack;
  reg_data_t   bus_rdata;
  logic        pps_o;
  logic        pps_dly_o;
  logic        lmk_sync_o;

  logic [31:0] lfsr = 32'h9ebe;
  int          errors = 0;
  int          checks = 0;
  int          cyc = 0;
  // Model state holds the generator counters, the external sync flops and a shadow config
  int          c10 = 0;
  int          c25 = 0;
  logic        g10 = 0;
  logic        g25 = 0;
  logic        s1 = 0;
  logic        s2 = 0;
  logic        exp_pps;
  logic        prev_pps = 0;
  int          model_sel = 0;
  int          model_dly = 0;
  logic        pps_chk = 0;
  logic        dly_chk = 0;
  logic        hist [0:127];
  int          rise_cnt = 0;
  int          rise_cyc = 0;
  int          lmk_cnt = 0;
  int          lmk_cyc = 0;

  pps_sync_top UUT (
    .base_ref_clk (base_ref_clk),
    .brc_rst      (brc_rst),
    .pps_ext_i    (pps_ext_i),
    .bus_req_i    (bus_req),
    .bus_cmd_i    (bus_cmd),
    .bus_ack_o    (bus_ack),
    .bus_rdata_o  (bus_rdata),
    .pps_o        (pps_o),
    .pps_dly_o    (pps_dly_o),
    .lmk_sync_o   (lmk_sync_o)
  );

  always #2 base_ref_clk = ~base_ref_clk;

  // Fibonacci LFSR with taps at 32 22 2 and 1 that steps once per bit
  function automatic logic next_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  task automatic check(input logic ok, input string msg);
    checks++;
    if (!ok) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end
  endtask

  // ------------------------------------------------------------
  // Cycle model sampled half a nanosecond after each rising edge
  // ------------------------------------------------------------
  always begin
    @(posedge base_ref_clk);
    #0.5;
    exp_pps = brc_rst ? 1'b0 : (model_sel == 0 ? g10 : (model_sel == 1 ? g25 : s2));
    s2 = brc_rst ? 1'b0 : s1;
    s1 = brc_rst ? 1'b0 : pps_ext_i;
    g10 = brc_rst ? 1'b0 : (c10 < P10 / 4);
    g25 = brc_rst ? 1'b0 : (c25 < P25 / 4);
    c10 = brc_rst ? 0 : (c10 == P10 - 1 ? 0 : c10 + 1);
    c25 = brc_rst ? 0 : (c25 == P25 - 1 ? 0 : c25 + 1);
    if (pps_chk) begin
      check(pps_o === exp_pps, $sformatf("pps_o %b, model %b", pps_o, exp_pps));
    end
    // Delayed PPS against the recorded pps_o history
    if (dly_chk) begin
      check(pps_dly_o === hist[(cyc - model_dly - 1) & 127],
            $sformatf("pps_dly_o %b wrong for tap %0d", pps_dly_o, model_dly));
    end
    hist[cyc & 127] = pps_o;
    if (pps_o && !prev_pps) begin
      rise_cnt++;
      rise_cyc = cyc;
    end
    prev_pps = pps_o;
    if (lmk_sync_o) begin
      lmk_cnt++;
      lmk_cyc = cyc;
    end
    cyc++;
  end

  // Testbench tasks look at outputs after the model and drive at +1 ns
  task automatic wait_sample();
    @(posedge base_ref_clk);
    #0.7;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) wait_sample();
    #0.3;
  endtask

  // One four-phase access that starts and ends at a drive point
  task automatic bus_access(input logic wr, input reg_addr_t a, input reg_data_t d,
                            output reg_data_t rd);
    bus_cmd.write = wr;
    bus_cmd.addr  = a;
    bus_cmd.wdata = d;
    bus_req = 1'b1;
    wait_sample();
    check(bus_ack === 1'b1, "ack not high one cycle after req");
    rd = bus_rdata;
    #0.3;
    bus_req = 1'b0;
    wait_sample();
    check(bus_ack === 1'b0, "ack not low one cycle after req dropped");
    #0.3;
  endtask

  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    reg_data_t rd;
    bus_access(1'b1, a, d, rd);
  endtask

  task automatic bus_read_check(input reg_addr_t a, input reg_data_t exp);
    reg_data_t rd;
    bus_access(1'b0, a, 16'h0, rd);
    check(rd === exp, $sformatf("reg %0d read %h, expected %h", a, rd, exp));
  endtask

  // Source switch with the pps compare paused over the mux change
  task automatic select_source(input int sel);
    pps_chk = 1'b0;
    bus_write(`REG_ADDR_CTRL, 16'(sel));
    model_sel = sel;
    wait_cycles(4);
    pps_chk = 1'b1;
  endtask

  task automatic set_delay(input int d);
    dly_chk = 1'b0;
    bus_write(`REG_ADDR_PPS_DLY, 16'(d));
    model_dly = d;
    dly_chk = 1'b1;
  endtask

  // Rise to rise length and high time of pps_o over two periods
  task automatic measure_periods(input int period);
    int r0;
    int len;
    int highs;
    r0 = rise_cnt;
    while (rise_cnt == r0) wait_sample();
    for (int p = 0; p < 2; p++) begin
      r0 = rise_cnt;
      len = 0;
      highs = 0;
      while (rise_cnt == r0) begin
        highs += (pps_o && len > 0) ? 1 : 0;
        wait_sample();
        len++;
      end
      // The rise sample itself was high too
      highs++;
      check(len == period, $sformatf("pps period %0d, expected %0d", len, period));
      check(highs == period / 4, $sformatf("pps high %0d, expected %0d", highs, period / 4));
    end
    #0.3;
  endtask

  task automatic run_sync(input int d);
    int r0;
    int l0;
    bus_write(`REG_ADDR_SYNC_DLY, 16'(d));
    // Arm just after a falling edge so the next rise is far away
    while (!pps_o) wait_sample();
    while (pps_o) wait_sample();
    #0.3;
    l0 = lmk_cnt;
    r0 = rise_cnt;
    bus_write(`REG_ADDR_CTRL, 16'h0010);
    while (rise_cnt == r0) wait_sample();
    #0.3;
    wait_cycles(d + 6);
    check(lmk_cnt == l0 + 1, $sformatf("saw %0d SYNC pulses, expected 1", lmk_cnt - l0));
    check(lmk_cyc == rise_cyc + d + 3,
          $sformatf("SYNC at +%0d cycles, expected +%0d", lmk_cyc - rise_cyc, d + 3));
    bus_read_check(`REG_ADDR_STATUS, 16'h0001);
    bus_write(`REG_ADDR_CTRL, 16'h0000);
    bus_read_check(`REG_ADDR_STATUS, 16'h0000);
    l0 = lmk_cnt;
    wait_cycles(P10 + 50);
    check(lmk_cnt == l0, "SYNC issued after the trigger was cleared");
  endtask

  initial begin
    #(RUN_CYCLES * 4);
    $display("Watchdog timeout: the tests did not finish in %0d cycles", RUN_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    reg_addr_t a;
    reg_data_t d;
    int        w;
    base_ref_clk = 1'b0;
    brc_rst      = 1'b1;
    pps_ext_i    = 1'b0;
    bus_req      = 1'b0;
    bus_cmd      = '0;
    // History starts as the zeros the delay line shift register resets to
    for (int i = 0; i < 128; i++) begin
      hist[i] = 1'b0;
    end
    repeat (3) @(posedge base_ref_clk);
    #1;
    brc_rst = 1'b0;

    // ------------------------------------------------------------
    // Register access with the trigger bit clear so the FSM stays idle
    // ------------------------------------------------------------
    for (int i = 0; i < 8; i++) begin
      a = reg_addr_t'(rand_bits(2) % 3);
      d = reg_data_t'(rand_bits(16)) & ~16'h0010;
      bus_write(a, d);
      bus_read_check(a, d & (a == `REG_ADDR_CTRL ? 16'h0013 :
                             a == `REG_ADDR_SYNC_DLY ? 16'h00ff : 16'h003f));
    end
    set_delay(rand_bits(6));

    // Internal generators
    select_source(0);
    measure_periods(P10);
    select_source(1);
    measure_periods(P25);

    // External source with the delay tap moved every round
    for (int sel = 2; sel < 4; sel++) begin
      select_source(sel);
      for (int r = 0; r < EXT_ROUNDS; r++) begin
        set_delay(rand_bits(6));
        w = 1 + rand_bits(4);
        pps_ext_i = 1'b1;
        wait_cycles(w);
        pps_ext_i = 1'b0;
        wait_cycles(4 + rand_bits(6));
      end
    end

    // LMK SYNC from the 10M generator
    dly_chk = 1'b0;
    select_source(0);
    run_sync(rand_bits(8));
    run_sync(rand_bits(8))

;

    // Mid-run reset with the 25M source selected and a read holding ack up
    // The model is reset by the same signal
    select_source(1);
    bus_cmd = '0;
    bus_req = 1'b1;
    wait_cycles(1);
    brc_rst = 1'b1;
    model_sel = 0;
    model_dly = 0;
    for (int i = 0; i < 3; i++) begin
      wait_sample();
      check(!pps_o && !lmk_sync_o && !bus_ack, "outputs not low during reset");
    end
    #0.3;
    brc_rst = 1'b0;
    bus_req = 1'b0;
    for (int i = 0; i < 4; i++) begin
      bus_read_check(reg_addr_t'(i), 16'h0000);
    end
    measure_periods(P10);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pps_sync.f
+incdir+source
source/pps_sync_pkg.sv
source/pps_pulse_gen.sv
source/pps_source_select.sv
source/pps_sync_regs.sv
source/lmk_sync_ctrl.sv
source/pps_delay_line.sv
source/pps_sync_top.sv
bench/pps_sync_checker.sv
bench/pps_sync_tb.sv

// File: Makefile
SIM := obj_dir/Vpps_sync_tb
SRCS := $(shell grep -v '^+' pps_sync.f)

.PHONY: run clean

# Rebuilt only when the file list, a source or the defines header changes
$(SIM): pps_sync.f $(SRCS) source/pps_sync_defs.svh
	verilator --binary --timing --assert --top-module pps_sync_tb \
		-f pps_sync.f -o Vpps_sync_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log
